//--- source/imuldiv_pkg.sv
// shared types and constants for the integer multiply/divide unit
// imported by every RTL module of the unit and by the testbench
package imuldiv_pkg;

  // ------------------------------------------------------------
  // widths that carry a meaning
  // ------------------------------------------------------------
  typedef logic [31:0] operand_t;
  // product, or remainder in [63:32] and quotient in [31:0]
  typedef logic [63:0] result_t;

  // iteration counts of the two engines
  localparam int DIV_STEPS = 32;
  localparam int MUL_STEPS = 16;
  // outstanding requests tracked by the dispatch order queue
  localparam int ORDER_DEPTH = 2;

  localparam int DIV_CNT_W = $clog2(DIV_STEPS);
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);
  localparam int ORDER_PTR_W = $clog2(ORDER_DEPTH);
  localparam int ORDER_CNT_W = $clog2(ORDER_DEPTH + 1);

  // ------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    FN_MUL  = 3'd0,  // signed multiply, full 64-bit product
    FN_DIV  = 3'd1,  // signed divide
    FN_DIVU = 3'd2   // unsigned divide
  } muldiv_fn_t;

  // engine that serves a request, also the order queue tag
  typedef enum logic {
    ENG_MUL = 1'b0,
    ENG_DIV = 1'b1
  } engine_t;

  // shared by divider control and multiplier
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } engine_state_t;

  // 67 bits, fn on top
  typedef struct packed {
    muldiv_fn_t fn;
    operand_t   a;
    operand_t   b;
  } muldiv_req_t;

  typedef struct packed {
    result_t result;
  } muldiv_resp_t;

endpackage

//--- source/imuldiv_div_ctrl.sv
// control FSM of the iterative divider; drives the enables and select of
// imuldiv_div_dpath and owns the request and response handshakes
module imuldiv_div_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel
);

  engine_state_t        state;
  logic [DIV_CNT_W-1:0] step_cnt;
  logic                 req_go;
  logic                 resp_go;
  logic                 last_step;

  // handshake events
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (step_cnt == DIV_CNT_W'(DIV_STEPS - 1));

  // ------------------------------------------------------------
  // state and step counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state    <= ST_CALC;
            step_cnt <= '0;
          end
        end
        ST_CALC: begin
          // one quotient bit per cycle
          if (last_step) begin
            state <= ST_DONE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        ST_DONE: begin
          // hold the result until the consumer takes it
          if (resp_go) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------------------
  always_comb begin
    req_rdy   = (state == ST_IDLE);
    resp_val  = (state == ST_DONE);
    // idle: capture operands and init remainder/quotient on accept
    a_en      = (state == ST_IDLE) ? req_go : (state == ST_CALC);
    b_en      = (state == ST_IDLE) && req_go;
    // calc: feed the shift-subtract step back into the register
    a_mux_sel = (state == ST_CALC);
  end

  // counter stays within the step range
  a_step_range: assert property (@(posedge clk) disable iff (reset)
    step_cnt <= DIV_CNT_W'(DIV_STEPS - 1));

  // never accepting and responding in the same cycle
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

endmodule

//--- source/imuldiv_div_dpath.sv
// datapath of the iterative restoring divider; works on operand magnitudes
// and fixes the signs at the output. sequenced by imuldiv_div_ctrl
module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  muldiv_req_t req,
  input  logic        a_en,
  input  logic        b_en,
  input  logic        a_mux_sel,
  output result_t     result
);

  // request decode
  logic        req_signed;
  operand_t    a_mag_in;
  operand_t    b_mag_in;

  // captured operands
  operand_t    dividend;
  operand_t    divisor_mag;
  logic        a_neg;
  logic        b_neg;
  logic        is_signed;

  // remainder in [64:32], quotient shifts in at [0]
  logic [64:0] rem_quot;
  logic [64:0] shifted;
  logic [64:0] diff;
  logic [64:0] step_out;

  // sign fixup
  operand_t    quot_mag;
  operand_t    rem_mag;
  operand_t    quot_fix;
  operand_t    rem_fix;
  logic        quot_neg;
  logic        rem_neg;
  logic        div_zero;

  // ------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------
  assign req_signed = (req.fn == FN_DIV);
  // most negative number maps to 2^31, which still fits unsigned
  assign a_mag_in = (req_signed && req.a[31]) ? -req.a : req.a;
  assign b_mag_in = (req_signed && req.b[31]) ? -req.b : req.b;

  // sign info is control state for the fixup
  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg     <= 1'b0;
      b_neg     <= 1'b0;
      is_signed <= 1'b0;
    end else if (b_en) begin
      a_neg     <= req.a[31];
      b_neg     <= req.b[31];
      is_signed <= req_signed;
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      dividend    <= req.a;
      divisor_mag <= b_mag_in;
    end
    if (a_en) begin
      rem_quot <= a_mux_sel ? step_out : {33'b0, a_mag_in};
    end
  end

  // ------------------------------------------------------------
  // restoring step
  // ------------------------------------------------------------
  assign shifted = rem_quot << 1;
  // divisor aligned with the remainder half, bit 64 acts as sign
  assign diff = shifted - {1'b0, divisor_mag, 32'b0};
  // negative difference: restore and shift in a zero
  assign step_out = diff[64] ? {shifted[64:1], 1'b0} : {diff[64:1], 1'b1};

  // ------------------------------------------------------------
  // sign fixup and special cases
  // ------------------------------------------------------------
  assign quot_mag = rem_quot[31:0];
  assign rem_mag  = rem_quot[63:32];

  assign quot_neg = is_signed && (a_neg ^ b_neg);
  // remainder follows the dividend
  assign rem_neg  = is_signed && a_neg;

  assign quot_fix = quot_neg ? -quot_mag : quot_mag;
  assign rem_fix  = rem_neg ? -rem_mag : rem_mag;

  // overflow case falls out of the magnitudes, zero divisor does not
  assign div_zero = (divisor_mag == '0);
  assign result = div_zero ? {dividend, 32'hffff_ffff} : {rem_fix, quot_fix};

endmodule

//--- source/imuldiv_mul_iterative.sv
// iterative signed 32x32 multiplier, radix 4 shift-add, full 64-bit product
// own FSM and valid/ready ports, one product in flight at a time
module imuldiv_mul_iterative import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         req_val,
  output logic         req_rdy,
  input  muldiv_req_t  req,
  output logic         resp_val,
  input  logic         resp_rdy,
  output muldiv_resp_t resp
);

  engine_state_t        state;
  logic [MUL_CNT_W-1:0] step_cnt;
  logic                 req_go;
  logic                 resp_go;
  logic                 last_step;

  // multiplicand moves up two bits per step
  result_t  mcand;
  // multiplier bits consumed from the bottom
  operand_t mplier;
  logic     mplier_neg;
  result_t  acc;
  result_t  partial;
  result_t  correction;

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (step_cnt == MUL_CNT_W'(MUL_STEPS - 1));

  assign req_rdy   = (state == ST_IDLE);
  assign resp_val  = (state == ST_DONE);

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state    <= ST_CALC;
            step_cnt <= '0;
          end
        end
        ST_CALC: begin
          if (last_step) begin
            state <= ST_DONE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        ST_DONE: begin
          if (resp_go) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // shift-add datapath
  // ------------------------------------------------------------
  // 0, 1, 2 or 3 times the multiplicand for the low two bits
  always_comb begin
    case (mplier[1:0])
      2'd0:    partial = '0;
      2'd1:    partial = mcand;
      2'd2:    partial = mcand << 1;
      default: partial = mcand + (mcand << 1);
    endcase
  end

  // multiplier bits were taken as unsigned, so a negative multiplier
  // overcounts by a * 2^32; mcand is a << 30 on the last step
  assign correction = (last_step && mplier_neg) ? (mcand << 2) : '0;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand      <= {{32{req.a[31]}}, req.a};
      mplier     <= req.b;
      mplier_neg <= req.b[31];
      acc        <= '0;
    end else if (state == ST_CALC) begin
      acc    <= acc + partial - correction;
      mcand  <= mcand << 2;
      mplier <= mplier >> 2;
    end
  end

  assign resp.result = acc;

  // product held while the consumer stalls
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp));

endmodule

//--- source/imuldiv_dispatch.sv
// routes requests to the multiplier or divider by fn and returns the
// responses in request order through a small queue of engine tags
module imuldiv_dispatch import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         req_val,
  output logic         req_rdy,
  input  muldiv_req_t  req,
  output logic         mul_req_val,
  input  logic         mul_req_rdy,
  output logic         div_req_val,
  input  logic         div_req_rdy,
  input  logic         mul_resp_val,
  output logic         mul_resp_rdy,
  input  muldiv_resp_t mul_resp,
  input  logic         div_resp_val,
  output logic         div_resp_rdy,
  input  muldiv_resp_t div_resp,
  output logic         resp_val,
  input  logic         resp_rdy,
  output muldiv_resp_t resp
);

  engine_t                sel_eng;
  logic                   eng_rdy;
  // order queue of engine tags
  engine_t                order_q [ORDER_DEPTH];
  logic [ORDER_PTR_W-1:0] wr_ptr;
  logic [ORDER_PTR_W-1:0] rd_ptr;
  logic [ORDER_CNT_W-1:0] q_cnt;
  logic                   q_full;
  logic                   q_empty;
  logic                   push;
  logic                   pop;
  engine_t                head;

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------
  assign sel_eng = (req.fn == FN_MUL) ? ENG_MUL : ENG_DIV;
  assign eng_rdy = (sel_eng == ENG_MUL) ? mul_req_rdy : div_req_rdy;

  assign q_full  = (q_cnt == ORDER_CNT_W'(ORDER_DEPTH));
  assign q_empty = (q_cnt == '0);

  // no slot for the tag means no transfer to either engine
  assign req_rdy     = eng_rdy && !q_full;
  assign mul_req_val = req_val && !q_full && (sel_eng == ENG_MUL);
  assign div_req_val = req_val && !q_full && (sel_eng == ENG_DIV);

  // ------------------------------------------------------------
  // response side, oldest tag picks the engine
  // ------------------------------------------------------------
  assign head = order_q[rd_ptr];

  assign resp_val     = !q_empty && ((head == ENG_MUL) ? mul_resp_val : div_resp_val);
  assign resp         = (head == ENG_MUL) ? mul_resp : div_resp;
  assign mul_resp_rdy = !q_empty && (head == ENG_MUL) && resp_rdy;
  assign div_resp_rdy = !q_empty && (head == ENG_DIV) && resp_rdy;

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= sel_eng;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ORDER_PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ORDER_PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (pop && !push) begin
        q_cnt <= q_cnt - 1'b1;
      end
    end
  end

  a_q_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !q_full);

  a_q_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> !q_empty);

endmodule

//--- source/imuldiv_unit.sv
// top level of the multiply/divide unit: one request port, one in-order
// response port; dispatch in front of the multiplier and divider
module imuldiv_unit import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         req_val,
  output logic         req_rdy,
  input  muldiv_req_t  req,
  output logic         resp_val,
  input  logic         resp_rdy,
  output muldiv_resp_t resp
);

  // dispatch to engine handshakes
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;
  logic         mul_resp_val;
  logic         mul_resp_rdy;
  logic         div_resp_val;
  logic         div_resp_rdy;
  muldiv_resp_t mul_resp;
  muldiv_resp_t div_resp;

  // divider control to datapath
  logic         a_en;
  logic         b_en;
  logic         a_mux_sel;

  imuldiv_dispatch dispatch (.*);

  imuldiv_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req      (req),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp     (mul_resp)
  );

  imuldiv_div_ctrl div_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel)
  );

  imuldiv_div_dpath div_dpath (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel),
    .result    (div_resp.result)
  );

endmodule

//--- test/imuldiv_unit_tb.sv
// testbench for the multiply/divide unit with directed corner cases, then LCG random
// traffic with resp_rdy stalls; checking is done by concurrent assertions
module imuldiv_unit_tb import imuldiv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_DIRECTED    = 15;
  localparam int          NUM_RANDOM      = 400;
  localparam int          NUM_OPS         = NUM_DIRECTED + NUM_RANDOM;
  localparam int          WATCHDOG_CYCLES = NUM_OPS * 40 + 200;
  // a full order queue of divides plus room for consumer stalls
  localparam int          DRAIN_CYCLES    = ORDER_DEPTH * (DIV_STEPS + 2) + 64;
  localparam int unsigned SEED            = 50;

  logic         clk = 1'b0;
  logic         reset;
  logic         req_val;
  logic         req_rdy;
  muldiv_req_t  req;
  logic         resp_val;
  logic         resp_rdy;
  muldiv_resp_t resp;

  // scoreboard with the oldest expected result at the front
  result_t      exp_q[$];
  int           exp_count = 0;
  result_t      exp_head  = '0;
  result_t      last_resp = '0;
  int unsigned  stim_state;
  // separate stream for the stalls derived from the same seed
  int unsigned  stall_state;

  imuldiv_unit uut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  always #4 clk = ~clk;

  // ------------------------------------------------------------
  // error reporting
  // ------------------------------------------------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_error(input string name, input result_t got, input result_t exp);
    stop_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  // ------------------------------------------------------------
  // random numbers and reference model
  // ------------------------------------------------------------
  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned rand_stim();
    stim_state = lcg_step(stim_state);
    // low LCG bits have short periods
    return stim_state >> 8;
  endfunction

  // operands biased toward 0, -1, the most negative number and small values
  function automatic operand_t pick_operand();
    int unsigned sel;
    int unsigned hi;
    int unsigned lo;
    sel = rand_stim() % 8;
    hi  = rand_stim();
    lo  = rand_stim();
    case (sel)
      0:       return 32'h0000_0000;
      1:       return 32'hffff_ffff;
      2:       return 32'h8000_0000;
      3:       return operand_t'(lo % 16);
      default: return {hi[15:0], lo[15:0]};
    endcase
  endfunction

  function automatic result_t expected_result(input muldiv_req_t r);
    int       sa;
    int       sb;
    longint   prod;
    operand_t quot;
    operand_t rem;
    sa = int'(r.a);
    sb = int'(r.b);
    if (r.fn == FN_MUL) begin
      prod = longint'(sa) * longint'(sb);
      return result_t'(prod);
    end
    // division by zero gives an all ones quotient and the dividend as remainder
    if (r.b == '0) begin
      return {r.a, 32'hffff_ffff};
    end
    if (r.fn == FN_DIVU) begin
      quot = r.a / r.b;
      rem  = r.a % r.b;
    end else if (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
      quot = 32'h8000_0000;
      rem  = '0;
    end else begin
      // truncating divide where the remainder takes the dividend's sign
      quot = operand_t'(sa / sb);
      rem  = operand_t'(sa % sb);
    end
    return {rem, quot};
  endfunction

  // ------------------------------------------------------------
  // stimulus tasks are entered and left on a falling edge
  // ------------------------------------------------------------
  task automatic send_req(input muldiv_fn_t fn, input operand_t a, input operand_t b);
    req_val = 1'b1;
    req.fn  = fn;
    req.a   = a;
    req.b   = b;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    @(negedge clk);
    // a following call raises it again in the same time step
    req_val = 1'b0;
  endtask

  // wait for all outstanding responses or until max_cycles have passed
  task automatic wait_drain(input int max_cycles);
    int waited;
    waited = 0;
    while (exp_count != 0 && waited < max_cycles) begin
      @(negedge clk);
      waited++;
    end
  endtask

  // random consumer stalls with ready three times in four
  always @(negedge clk) begin
    stall_state = lcg_step(stall_state);
    resp_rdy    = (stall_state[31:30] != 2'b00);
  end

  // scoreboard update from the transfers of this edge
  always @(posedge clk) begin
    if (!reset) begin
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req));
      end
      if (resp_val && resp_rdy && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      exp_count = exp_q.size();
      exp_head  = (exp_count != 0) ? exp_q[0] : '0;
      last_resp = resp.result;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_resp_match: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> resp.result == exp_head)
    else value_error("resp.result", $sampled(resp.result), $sampled(exp_head));

  a_resp_expected: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> exp_count != 0)
    else stop_run("a response arrived with no request outstanding");

  // response held under stall
  a_stall_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp.result == last_resp)
    else value_error("resp.result", $sampled(resp.result), $sampled(last_resp));

  a_stall_valid: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else stop_run("resp_val dropped before the response was taken");

  // both engines idle right after reset
  a_reset_idle: assert property (@(posedge clk)
    $fell(reset) |-> req_rdy && !resp_val)
    else stop_run("unit was not ready and idle after reset");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("timeout: responses stopped arriving");
  end

  initial begin
    stim_state  = SEED;
    stall_state = SEED * 3 + 1;
    reset       = 1'b1;
    req_val     = 1'b0;
    req         = '0;
    resp_rdy    = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // unsigned divide
    send_req(FN_DIVU, 32'd100, 32'd7);
    send_req(FN_DIVU, 32'hffff_ffff, 32'd3);
    // signed divide sign rules and overflow
    send_req(FN_DIV, -32'sd7, 32'sd2);
    send_req(FN_DIV, 32'sd7, -32'sd2);
    send_req(FN_DIV, -32'sd7, -32'sd2);
    send_req(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    // division by zero
    send_req(FN_DIV, -32'sd5, 32'd0);
    send_req(FN_DIVU, 32'd1234, 32'd0);
    // signed multiply with negative and extreme operands
    send_req(FN_MUL, -32'sd3, 32'sd5);
    send_req(FN_MUL, 32'h8000_0000, 32'h8000_0000);
    send_req(FN_MUL, 32'h8000_0000, 32'hffff_ffff);
    send_req(FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
    send_req(FN_MUL, 32'hffff_ffff, 32'hffff_ffff);

    // divide then multiply back to back, multiply finishes first
    wait_drain(DRAIN_CYCLES);
    send_req(FN_DIVU, 32'h1234_5678, 32'd9);
    send_req(FN_MUL, 32'hdead_beef, 32'h0000_0013);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      send_req(muldiv_fn_t'(rand_stim() % 3), pick_operand(), pick_operand());
    end

    wait_drain(DRAIN_CYCLES);
    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d responses never arrived", exp_q.size()));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- imuldiv_unit.f
source/imuldiv_pkg.sv
source/imuldiv_div_ctrl.sv
source/imuldiv_div_dpath.sv
source/imuldiv_mul_iterative.sv
source/imuldiv_dispatch.sv
source/imuldiv_unit.sv
test/imuldiv_unit_tb.sv
